//--- hdl/blimp_pkg.sv
/*
  Shared sizes, RISC-V opcodes and the packets passed between the core units.
  Every unit refers to these by scoped name, so compile this package first.
*/
`default_nettype none

package blimp_pkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------
  localparam int XLEN          = 32;
  localparam int NUM_REGS      = 32;
  localparam int REG_ADDR_BITS = 5;
  localparam int SEQ_BITS      = 3;              // ROB index width
  localparam int ROB_DEPTH     = 1 << SEQ_BITS;  // 8 outstanding max
  localparam int IBUF_DEPTH    = 4;              // also the credits after reset
  localparam int IBUF_PTR_BITS = $clog2(IBUF_DEPTH);
  localparam int MUL_STAGES    = 4;
  localparam int NUM_XU        = 2;              // ALU, multiplier

  // ------------------------------------------------
  // Encodings
  // ------------------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;  // ADD, MUL
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // ADDI
  localparam logic [6:0] FUNCT7_MUL = 7'b0000001;  // M extension

  // R-type view
  typedef struct packed {
    logic [6:0]               funct7;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [2:0]               funct3;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [6:0]               opcode;
  } r_fmt_t;

  // I-type view, same rs1/rd/opcode slots
  typedef struct packed {
    logic [11:0]              imm;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [2:0]               funct3;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [6:0]               opcode;
  } i_fmt_t;

  // One word, two decodings
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_u;

  // ------------------------------------------------
  // Inter-unit packets
  // ------------------------------------------------
  typedef struct packed {
    logic                     val;
    logic [SEQ_BITS-1:0]      seq;
    logic [REG_ADDR_BITS-1:0] waddr;
    logic                     wen;    // Low for rd == x0
    logic [XLEN-1:0]          op_a;
    logic [XLEN-1:0]          op_b;   // rs2 or sign-extended imm
  } issue_t;

  typedef struct packed {
    logic                     val;
    logic [SEQ_BITS-1:0]      seq;
    logic [REG_ADDR_BITS-1:0] waddr;
    logic                     wen;
    logic [XLEN-1:0]          wdata;
  } complete_t;

  // Commit trace record
  typedef struct packed {
    logic                     val;
    logic [SEQ_BITS-1:0]      seq;
    logic [REG_ADDR_BITS-1:0] waddr;
    logic                     wen;
    logic [XLEN-1:0]          wdata;  // Zero when wen low
  } commit_t;

endpackage

`default_nettype wire

//--- hdl/decode_issue_unit.sv
/*
  Front of the core. Buffers incoming instruction words under credit control,
  decodes the oldest one, reads the register file and dispatches it to the ALU
  or the multiplier once the scoreboard and reorder buffer allow.
*/
`timescale 1ns/1ps
`default_nettype none

module decode_issue_unit (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      inst_val,
  input  blimp_pkg::inst_u                          inst_word,
  output logic                                      inst_credit,
  output blimp_pkg::issue_t                         alu_issue,
  output blimp_pkg::issue_t                         mul_issue,
  input  blimp_pkg::complete_t [blimp_pkg::NUM_XU-1:0] completions,
  input  blimp_pkg::commit_t                        commit
);

  blimp_pkg::inst_u                         ibuf [blimp_pkg::IBUF_DEPTH];
  logic [blimp_pkg::IBUF_PTR_BITS-1:0]      wr_ptr;
  logic [blimp_pkg::IBUF_PTR_BITS-1:0]      rd_ptr;
  logic [blimp_pkg::IBUF_PTR_BITS:0]        ibuf_cnt;
  logic [blimp_pkg::XLEN-1:0]               rf [blimp_pkg::NUM_REGS];
  logic [blimp_pkg::NUM_REGS-1:0]           pending;   // Scoreboard, one bit per reg
  logic [blimp_pkg::SEQ_BITS:0]             rob_cnt;   // Outstanding ROB entries
  logic [blimp_pkg::SEQ_BITS-1:0]           next_seq;

  blimp_pkg::inst_u                         head;
  logic [blimp_pkg::REG_ADDR_BITS-1:0]      rs1;
  logic [blimp_pkg::REG_ADDR_BITS-1:0]      rs2;
  logic [blimp_pkg::REG_ADDR_BITS-1:0]      rd;
  logic                                     is_mul;
  logic                                     is_imm;
  logic                                     hazard;
  logic                                     dispatch;
  blimp_pkg::issue_t                        issue_pkt;

  // ------------------------------------------------
  // Decode of the buffer head
  // ------------------------------------------------
  assign head   = ibuf[rd_ptr];
  assign rs1    = head.r.rs1;              // Same slot in both formats
  assign rs2    = head.r.rs2;
  assign rd     = head.r.rd;
  assign is_imm = (head.i.opcode == blimp_pkg::OPC_OP_IMM);
  assign is_mul = (head.r.opcode == blimp_pkg::OPC_OP) &&
                  (head.r.funct7 == blimp_pkg::FUNCT7_MUL);

  // rs2 field is immediate bits for ADDI, so ignore it there
  assign hazard = pending[rs1] || (!is_imm && pending[rs2]) || pending[rd];

  assign dispatch = (ibuf_cnt != '0) && !hazard &&
                    (rob_cnt < blimp_pkg::ROB_DEPTH);

  always_comb begin
    issue_pkt       = '0;
    issue_pkt.val   = 1'b0;                 // Set per unit at the register
    issue_pkt.seq   = next_seq;
    issue_pkt.waddr = rd;
    issue_pkt.wen   = (rd != '0);           // x0 writes are dropped
    issue_pkt.op_a  = (rs1 == '0) ? '0 : rf[rs1];
    if (is_imm)
      issue_pkt.op_b = {{(blimp_pkg::XLEN-12){head.i.imm[11]}}, head.i.imm};
    else
      issue_pkt.op_b = (rs2 == '0) ? '0 : rf[rs2];
  end

  // ------------------------------------------------
  // Instruction buffer
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (inst_val)
      ibuf[wr_ptr] <= inst_word;            // Producer never overruns its credits
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      ibuf_cnt <= '0;
    end else begin
      if (inst_val)
        wr_ptr <= wr_ptr + 1'b1;
      if (dispatch)
        rd_ptr <= rd_ptr + 1'b1;
      ibuf_cnt <= ibuf_cnt + (inst_val ? 1'b1 : 1'b0) - (dispatch ? 1'b1 : 1'b0);
    end
  end

  // ------------------------------------------------
  // Register file, two completion write ports
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < blimp_pkg::NUM_XU; i++) begin
      if (completions[i].val && completions[i].wen)
        rf[completions[i].waddr] <= completions[i].wdata;
    end
  end

  // Scoreboard and sequence bookkeeping
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending  <= '0;
      rob_cnt  <= '0;
      next_seq <= '0;
    end else begin
      for (int i = 0; i < blimp_pkg::NUM_XU; i++) begin
        if (completions[i].val && completions[i].wen)
          pending[completions[i].waddr] <= 1'b0;   // Dependents may go next cycle
      end
      if (dispatch && issue_pkt.wen)
        pending[rd] <= 1'b1;
      if (dispatch)
        next_seq <= next_seq + 1'b1;               // Wraps modulo ROB depth
      rob_cnt <= rob_cnt + (dispatch ? 1'b1 : 1'b0) - (commit.val ? 1'b1 : 1'b0);
    end
  end

  // ------------------------------------------------
  // Registered dispatch and credit return
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    alu_issue <= issue_pkt;                        // Payload, no reset
    mul_issue <= issue_pkt;
    if (!rst_n) begin
      alu_issue.val <= 1'b0;
      mul_issue.val <= 1'b0;
      inst_credit   <= 1'b0;
    end else begin
      alu_issue.val <= dispatch && !is_mul;
      mul_issue.val <= dispatch && is_mul;
      inst_credit   <= dispatch;                   // Entry left the buffer
    end
  end

endmodule

`default_nettype wire

//--- hdl/alu_unit.sv
/*
  Single-cycle execute unit for ADD and ADDI. Decode has already picked the
  second operand, so both reduce to one add with a registered completion.
*/
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  blimp_pkg::issue_t    issue,
  output blimp_pkg::complete_t complete
);

  logic [blimp_pkg::XLEN-1:0] sum;

  assign sum = issue.op_a + issue.op_b;  // Carry out dropped

  // Completion valid one cycle after issue
  always_ff @(posedge clk) begin
    complete.seq   <= issue.seq;
    complete.waddr <= issue.waddr;
    complete.wen   <= issue.wen;
    complete.wdata <= sum;
    if (!rst_n)
      complete.val <= 1'b0;
    else
      complete.val <= issue.val;
  end

endmodule

`default_nettype wire

//--- hdl/pipelined_multiplier.sv
/*
  Pipelined 32x32 multiplier keeping the low word of the product. Partial
  products in stage 0, summed in stage 1, then carried to the end so the
  completion appears MUL_STAGES cycles after issue. Accepts one op per cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module pipelined_multiplier (
  input  logic                 clk,
  input  logic                 rst_n,
  input  blimp_pkg::issue_t    issue,
  output blimp_pkg::complete_t complete
);

  blimp_pkg::complete_t         stage [blimp_pkg::MUL_STAGES];  // val per stage
  logic [blimp_pkg::XLEN/2-1:0] cross_q;                        // Cross terms, low half
  logic [blimp_pkg::XLEN-1:0]   pp_ll;
  logic [blimp_pkg::XLEN/2-1:0] pp_lh;
  logic [blimp_pkg::XLEN/2-1:0] pp_hl;

  // 16x16 pieces, hi*hi falls outside the low word
  assign pp_ll = issue.op_a[blimp_pkg::XLEN/2-1:0] * issue.op_b[blimp_pkg::XLEN/2-1:0];
  assign pp_lh = issue.op_a[blimp_pkg::XLEN/2-1:0] *
                 issue.op_b[blimp_pkg::XLEN-1:blimp_pkg::XLEN/2];
  assign pp_hl = issue.op_a[blimp_pkg::XLEN-1:blimp_pkg::XLEN/2] *
                 issue.op_b[blimp_pkg::XLEN/2-1:0];

  always_ff @(posedge clk) begin
    // Stage 0 holds ll product in wdata
    stage[0].seq   <= issue.seq;
    stage[0].waddr <= issue.waddr;
    stage[0].wen   <= issue.wen;
    stage[0].wdata <= pp_ll;
    cross_q        <= pp_lh + pp_hl;
    // Stage 1 finishes the sum
    stage[1]       <= stage[0];
    stage[1].wdata <= stage[0].wdata + {cross_q, {(blimp_pkg::XLEN/2){1'b0}}};
    for (int i = 2; i < blimp_pkg::MUL_STAGES; i++)
      stage[i] <= stage[i-1];                // Plain delay stages
    if (!rst_n) begin
      for (int i = 0; i < blimp_pkg::MUL_STAGES; i++)
        stage[i].val <= 1'b0;
    end else begin
      stage[0].val <= issue.val;
    end
  end

  assign complete = stage[blimp_pkg::MUL_STAGES-1];

endmodule

`default_nettype wire

//--- hdl/writeback_commit_unit.sv
/*
  Reorder buffer indexed by sequence number. Completions from both execute
  units mark entries done in any order; the head entry retires in program
  order as a registered commit record, at most one per cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module writeback_commit_unit (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  blimp_pkg::complete_t [blimp_pkg::NUM_XU-1:0] completions,
  output blimp_pkg::commit_t                           commit
);

  // ------------------------------------------------
  // ROB storage
  // ------------------------------------------------
  logic [blimp_pkg::ROB_DEPTH-1:0]     rob_done;
  logic [blimp_pkg::REG_ADDR_BITS-1:0] rob_waddr [blimp_pkg::ROB_DEPTH];
  logic                                rob_wen   [blimp_pkg::ROB_DEPTH];
  logic [blimp_pkg::XLEN-1:0]          rob_wdata [blimp_pkg::ROB_DEPTH];
  logic [blimp_pkg::SEQ_BITS-1:0]      head_ptr;   // Oldest uncommitted seq
  logic                                head_done;

  assign head_done = rob_done[head_ptr];

  // Payload fill, both ports in one cycle
  always_ff @(posedge clk) begin
    for (int i = 0; i < blimp_pkg::NUM_XU; i++) begin
      if (completions[i].val) begin
        rob_waddr[completions[i].seq] <= completions[i].waddr;
        rob_wen[completions[i].seq]   <= completions[i].wen;
        rob_wdata[completions[i].seq] <= completions[i].wdata;
      end
    end
  end

  // Done bits and head pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rob_done <= '0;
      head_ptr <= '0;
    end else begin
      if (head_done) begin
        rob_done[head_ptr] <= 1'b0;             // Slot free for reuse
        head_ptr           <= head_ptr + 1'b1;  // Wraps with seq
      end
      for (int i = 0; i < blimp_pkg::NUM_XU; i++) begin
        if (completions[i].val)
          rob_done[completions[i].seq] <= 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // Commit record, one cycle after head done
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    commit.seq   <= head_ptr;
    commit.waddr <= rob_waddr[head_ptr];
    commit.wen   <= rob_wen[head_ptr];
    // x0 writes show zero data on the trace
    commit.wdata <= rob_wen[head_ptr] ? rob_wdata[head_ptr] : '0;
    if (!rst_n)
      commit.val <= 1'b0;
    else
      commit.val <= head_done;
  end

endmodule

`default_nettype wire

//--- hdl/blimp_core.sv
/*
  Core top level. Instruction words enter under credit flow control and
  retire in program order on the commit trace port. Decode dispatches to the
  ALU or the multiplier, results complete out of order into the ROB.
*/
`timescale 1ns/1ps
`default_nettype none

module blimp_core (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               inst_val,
  input  blimp_pkg::inst_u   inst_word,
  output logic               inst_credit,
  output blimp_pkg::commit_t commit
);

  // ------------------------------------------------
  // Internal links, no handshake needed
  // ------------------------------------------------
  blimp_pkg::issue_t                            alu_issue;
  blimp_pkg::issue_t                            mul_issue;
  blimp_pkg::complete_t [blimp_pkg::NUM_XU-1:0] completions;  // [0] ALU, [1] MUL

  decode_issue_unit decode_issue_unit_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_val    (inst_val),
    .inst_word   (inst_word),
    .inst_credit (inst_credit),
    .alu_issue   (alu_issue),
    .mul_issue   (mul_issue),
    .completions (completions),
    .commit      (commit)        // Frees ROB slots
  );

  alu_unit alu_unit_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (alu_issue),
    .complete (completions[0])
  );

  pipelined_multiplier pipelined_multiplier_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (mul_issue),
    .complete (completions[1])
  );

  writeback_commit_unit writeback_commit_unit_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .completions (completions),
    .commit      (commit)
  );

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
/*
  Testbench clock and reset source. 20 ns clock, rst_n held low for the
  first 5 rising edges and released just after the fifth.
*/
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;    // 20 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;           // Same 1 ns skew as the stimulus
  end

endmodule

`default_nettype wire

//--- tb/blimp_core_tb.sv
/*
  Testbench for the core. Plays the fetch side under credit flow control with
  random idle gaps, and checks each commit record against the golden file.
  Run from the project root so the golden file path resolves.
*/
`timescale 1ns/1ps
`default_nettype none

module blimp_core_tb;

  logic               clk;
  logic               rst_n;
  logic               inst_val;
  blimp_pkg::inst_u   inst_word;
  logic               inst_credit;
  blimp_pkg::commit_t commit;

  logic [63:0] golden [0:63];  // Count, then words, then records
  int          n_inst;
  int          sent;
  int          committed;
  int          credits;          // Producer side credit count
  int          cycle;
  int          cycle_limit;
  int          seed;
  int          value_errors;
  int          protocol_errors;
  int          timeout_errors;

  clock_gen clock_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  blimp_core blimp_core_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_val    (inst_val),
    .inst_word   (inst_word),
    .inst_credit (inst_credit),
    .commit      (commit)
  );

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  task automatic check_commit_record(input int idx);
    logic [63:0]                         rec;
    logic [blimp_pkg::SEQ_BITS-1:0]      exp_seq;
    logic                                exp_wen;
    logic [blimp_pkg::REG_ADDR_BITS-1:0] exp_waddr;
    logic [blimp_pkg::XLEN-1:0]          exp_wdata;
    rec       = golden[1 + n_inst + idx];
    exp_seq   = rec[40:38];              // {seq, wen, waddr, wdata}
    exp_wen   = rec[37];
    exp_waddr = rec[36:32];
    exp_wdata = rec[31:0];
    assert (commit.seq == exp_seq) else begin
      $display("[FAIL] commit.seq rec %0d exp %h got %h", idx, exp_seq, commit.seq);
      value_errors++;
    end
    assert (commit.wen == exp_wen) else begin
      $display("[FAIL] commit.wen rec %0d exp %h got %h", idx, exp_wen, commit.wen);
      value_errors++;
    end
    assert (commit.waddr == exp_waddr) else begin
      $display("[FAIL] commit.waddr rec %0d exp %h got %h", idx, exp_waddr, commit.waddr);
      value_errors++;
    end
    assert (commit.wdata == exp_wdata) else begin
      $display("[FAIL] commit.wdata rec %0d exp %h got %h", idx, exp_wdata, commit.wdata);
      value_errors++;
    end
  endtask

  task automatic check_credit_range();
    assert (credits >= 0 && credits <= blimp_pkg::IBUF_DEPTH) else begin
      $display("Protocol error at cycle %0d: producer holds %0d credits, outside 0 to %0d",
               cycle, credits, blimp_pkg::IBUF_DEPTH);
      protocol_errors++;
    end
  endtask

  // Outputs settle well before the 1 ns point
  task automatic step_cycle();
    @(posedge clk);
    #1;
    cycle++;
  endtask

  // ------------------------------------------------
  // Stimulus and scoring
  // ------------------------------------------------
  initial begin
    inst_val        = 1'b0;
    inst_word       = '0;
    seed            = 32'heabb9198;
    sent            = 0;
    committed       = 0;
    cycle           = 0;
    credits         = blimp_pkg::IBUF_DEPTH;  // Full buffer after reset
    value_errors    = 0;
    protocol_errors = 0;
    timeout_errors  = 0;
    $readmemh("tb/blimp_golden.hex", golden);
    n_inst      = int'(golden[0][15:0]);
    cycle_limit = 20 * n_inst + 100;
    if (n_inst < 1 || 2 * n_inst + 1 > $size(golden)) begin
      $display("Golden file gives an unusable instruction count of %0d", n_inst);
      protocol_errors++;
      n_inst = 0;
    end
    while (rst_n !== 1'b1)
      @(posedge clk);

    while (committed < n_inst && cycle < cycle_limit) begin
      step_cycle();
      inst_val = 1'b0;
      if (inst_credit)
        credits++;                           // One pulse, one credit back
      if (commit.val) begin
        check_commit_record(committed);
        committed++;
      end
      // Roughly one idle cycle in four
      if (sent < n_inst && credits > 0 && ($random(seed) & 3) != 0) begin
        inst_word = golden[1 + sent][31:0];
        inst_val  = 1'b1;
        credits--;
        sent++;
      end
      check_credit_range();
    end

    if (committed < n_inst) begin
      $display("Timeout: %0d of %0d instructions committed within %0d cycles",
               committed, n_inst, cycle_limit);
      timeout_errors++;
    end else begin
      // Drain, nothing may commit twice
      repeat (10) begin
        step_cycle();
        inst_val = 1'b0;
        if (inst_credit)
          credits++;
        check_credit_range();
        assert (!commit.val) else begin
          $display("Commit seen after the last instruction, seq %h", commit.seq);
          protocol_errors++;
        end
      end
      assert (credits == blimp_pkg::IBUF_DEPTH) else begin
        $display("Core did not return every credit, producer holds %0d", credits);
        protocol_errors++;
      end
    end

    $display("Errors: %0d value, %0d protocol, %0d timeout",
             value_errors, protocol_errors, timeout_errors);
    if (value_errors + protocol_errors + timeout_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/blimp_golden.hex
// Entry 0 is the instruction count N, then N instruction words,
// then N commit records packed as {seq[2:0], wen, waddr[4:0], wdata[31:0]}
18
// ADDI/ADD dependence chain on x1..x4
00500093 00708113 002081B3 003181B3 FFF18213
// MUL x5 then independent ADDIs, a write to x0, a read of x0
022202B3 06400313 FFD00393 00108413 00908013 006004B3
// Ten back-to-back MULs, a dependent MUL, ADD reading x0, x0 nop
02210533 024185B3 02638633 028086B3 02630733
027387B3 02218833 024208B3 02748933 021289B3
02C70A33 000A0AB3 00000013
// Expected commit records, program order, seq wraps modulo 8
02100000005 0620000000C 0A300000011 0E300000022
12400000021 1650000018C 1A600000064 1E7FFFFFFFD
02800000006 04000000000 0A900000064 0EA00000090
12B00000462 16CFFFFFED4 1AD0000001E 1EE00002710
02F00000009 07000000198 0B100000441 0F2FFFFFED4
133000007BC 174FFD23940 1B5FFD23940 1C000000000

//--- compile.f
hdl/blimp_pkg.sv
hdl/decode_issue_unit.sv
hdl/alu_unit.sv
hdl/pipelined_multiplier.sv
hdl/writeback_commit_unit.sv
hdl/blimp_core.sv
tb/clock_gen.sv
tb/blimp_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the blimp_core testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module blimp_core_tb -o sim_blimp
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_blimp > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
  echo "No pass line found in $LOG"
  exit 1
fi
exit 0
